/* build.f */
rtl/afifo_pkg.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_mem.sv
rtl/afifo_rd_ctrl.sv
rtl/afifo_top.sv
verif/afifo_clk_gen.sv
verif/afifo_checker.sv
verif/afifo_assertions.sv
verif/afifo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FIFO simulation with Verilator.
# Pass or fail is decided from sim.log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'
PASS_MSG='*** TEST PASSED ***'

verilator --binary --timing --assert \
    -f build.f \
    --top-module afifo_tb \
    -o afifo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/afifo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
    echo "result: failed"
    exit 1
fi

if ! grep -qF "$PASS_MSG" "$LOG"; then
    echo "result: no pass message in $LOG"
    exit 1
fi

echo "result: passed"
exit 0

/* verif/afifo_tb.sv */
//----------------------------------------------------------------------
// FIFO testbench: table of streams driven through both ports
//----------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_tb;
    import afifo_pkg::*;

    localparam int MODE_READY = 0;
    localparam int MODE_LFSR  = 1;
    localparam int MODE_STALL = 2;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_ROWS   = 5;

    typedef struct {
        string name;
        int    count;
        int    base;
        int    frame;
        int    mode;
        logic  fast;
    } row_t;

    logic        wclk;
    logic        rclk;
    logic        wrst_n;
    logic        rrst_n;
    logic        rclk_fast = 1'b0;
    logic        in_valid;
    logic        in_ready;
    fifo_entry_t in_entry;
    logic        out_valid;
    logic        out_ready;
    fifo_entry_t out_entry;
    logic [31:0] lfsr_state;
    row_t        rows [NUM_ROWS];

    afifo_clk_gen #(.PERIOD(40), .ALT_PERIOD(40), .RST_CYCLES(10)) i_wclk_gen (
        .alt_sel (1'b0),
        .clk     (wclk),
        .rst_n   (wrst_n)
    );

    afifo_clk_gen #(.PERIOD(40), .ALT_PERIOD(28), .RST_CYCLES(10)) i_rclk_gen (
        .alt_sel (rclk_fast),
        .clk     (rclk),
        .rst_n   (rrst_n)
    );

    afifo_top #(.ADDR_W(4)) i_dut (
        .wclk      (wclk),
        .wrst_n    (wrst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_entry  (in_entry),
        .rclk      (rclk),
        .rrst_n    (rrst_n),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_entry (out_entry)
    );

    afifo_checker i_checker (
        .wclk      (wclk),
        .rclk      (rclk),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_entry  (in_entry),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_entry (out_entry)
    );

    task automatic set_row(input int idx, input string name, input int count, input int base,
                           input int frame, input int mode, input logic fast);
        rows[idx].name  = name;
        rows[idx].count = count;
        rows[idx].base  = base;
        rows[idx].frame = frame;
        rows[idx].mode  = mode;
        rows[idx].fast  = fast;
    endtask

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // data is base plus index, last on every frame-th entry
    function automatic fifo_entry_t make_entry(input int base, input int idx, input int frame);
        fifo_entry_t e;
        e.data = fifo_word_t'(base + idx);
        e.last = ((idx + 1) % frame) == 0;
        return e;
    endfunction

    task automatic write_stream(input int count, input int base, input int frame);
        int   waits;
        logic accepted;
        @(posedge wclk);
        #2;
        for (int i = 0; i < count; i++) begin
            in_valid = 1'b1;
            in_entry = make_entry(base, i, frame);
            waits    = 0;
            accepted = 1'b0;
            while (!accepted && waits < WAIT_LIMIT) begin
                @(negedge wclk);
                accepted = in_ready;
                waits++;
                @(posedge wclk);
                #2;
            end
            if (!accepted) begin
                i_checker.report_problem("the writer timed out waiting for in_ready");
                break;
            end
        end
        in_valid = 1'b0;
    endtask

    // hold the reader off until in_ready has been low for 20 cycles
    task automatic wait_full_stall();
        int low;
        int cycles;
        low    = 0;
        cycles = 0;
        while (low < 20 && cycles < WAIT_LIMIT) begin
            @(negedge wclk);
            low = in_ready ? 0 : low + 1;
            cycles++;
        end
        if (low < 20) begin
            i_checker.report_problem("in_ready never stayed low under a stalled reader");
        end else begin
            i_checker.check_value("capacity", 17, i_checker.test_in);
        end
        @(posedge rclk);
        #2;
    endtask

    task automatic read_stream(input int count, input int mode);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        @(posedge rclk);
        #2;
        if (mode == MODE_STALL) begin
            out_ready = 1'b0;
            wait_full_stall();
        end
        while (got < count && idle < WAIT_LIMIT) begin
            if (mode == MODE_LFSR) begin
                out_ready = lfsr_step();
            end else begin
                out_ready = 1'b1;
            end
            @(negedge rclk);
            if (out_valid && out_ready) begin
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(posedge rclk);
            #2;
        end
        out_ready = 1'b1;
        if (got < count) begin
            i_checker.report_problem("the reader timed out before all entries came out");
        end
    endtask

    // out_valid must fall and stay low with nothing left queued
    task automatic drain_check();
        int n;
        n = 0;
        do begin
            @(negedge rclk);
            n++;
        end while (out_valid && n < WAIT_LIMIT);
        if (out_valid) begin
            i_checker.report_problem("out_valid did not fall after the last entry");
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge rclk);
            if (out_valid) begin
                i_checker.report_problem("out_valid rose again after the drain");
                break;
            end
        end
        i_checker.check_value("queue", 0, i_checker.pending());
    endtask

    task automatic reset_check();
        int n;
        n = 0;
        while ((!wrst_n || !rrst_n) && n < WAIT_LIMIT) begin
            @(negedge wclk);
            n++;
        end
        if (!wrst_n || !rrst_n) begin
            i_checker.report_problem("reset was never released");
        end
        @(negedge rclk);
        i_checker.check_value("out_valid", 0, int'(out_valid));
        @(negedge wclk);
        i_checker.check_value("in_ready", 1, int'(in_ready));
    endtask

    initial begin
        lfsr_state = 32'h3d7b_239c;
        in_valid   = 1'b0;
        in_entry   = '0;
        out_ready  = 1'b0;
        set_row(0, "order_ready", 40, 'h10, 4, MODE_READY, 1'b0);
        set_row(1, "lfsr_stalls", 60, 'h40, 5, MODE_LFSR, 1'b0);
        set_row(2, "capacity_stall", 30, 'h80, 3, MODE_STALL, 1'b0);
        set_row(3, "ratio_ready", 100, 'h05, 7, MODE_READY, 1'b1);
        set_row(4, "ratio_lfsr", 100, 'ha0, 6, MODE_LFSR, 1'b1);

        i_checker.start_test("reset_values");
        reset_check();
        i_checker.end_test();

        for (int r = 0; r < NUM_ROWS; r++) begin
            rclk_fast = rows[r].fast;
            i_checker.start_test(rows[r].name);
            fork
                write_stream(rows[r].count, rows[r].base, rows[r].frame);
                read_stream(rows[r].count, rows[r].mode);
            join
            drain_check();
            i_checker.end_test();
        end

        i_checker.report_totals();
        if (i_checker.err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/afifo_assertions.sv */
//----------------------------------------------------------------------
// FIFO assertions on the port handshakes, reset and write pointer
//----------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_assertions
    import afifo_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input logic            wclk,
    input logic            wrst_n,
    input logic            rclk,
    input logic            rrst_n,
    input logic            in_valid,
    input logic            in_ready,
    input fifo_entry_t     in_entry,
    input logic            out_valid,
    input logic            out_ready,
    input fifo_entry_t     out_entry,
    input logic [ADDR_W:0] wr_gptr
);

    in_hold: assert property (@(posedge wclk) disable iff (!wrst_n)
        in_valid && !in_ready |=> $stable(in_entry))
        else $error("in_entry changed while waiting for in_ready");

    out_hold: assert property (@(posedge rclk) disable iff (!rrst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_entry))
        else $error("out_entry not held under back-pressure");

    // low during reset and on the first two edges after it
    out_reset: assert property (@(posedge rclk)
        !rrst_n |-> !out_valid ##1 !out_valid ##1 !out_valid)
        else $error("out_valid high during or right after reset");

    wptr_hold: assert property (@(posedge wclk) disable iff (!wrst_n)
        !in_ready |=> $stable(wr_gptr))
        else $error("write pointer moved while in_ready was low");

endmodule

bind afifo_top afifo_assertions #(
    .ADDR_W (ADDR_W)
) i_assertions (
    .wclk      (wclk),
    .wrst_n    (wrst_n),
    .rclk      (rclk),
    .rrst_n    (rrst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_entry  (in_entry),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_entry (out_entry),
    .wr_gptr   (wr_gptr)
);

/* verif/afifo_checker.sv */
//----------------------------------------------------------------------
// FIFO scoreboard: records accepted input entries and compares the
// read stream against them in order
//----------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_checker
    import afifo_pkg::*;
(
    input logic        wclk,
    input logic        rclk,
    input logic        in_valid,
    input logic        in_ready,
    input fifo_entry_t in_entry,
    input logic        out_valid,
    input logic        out_ready,
    input fifo_entry_t out_entry
);

    fifo_entry_t exp_q[$];
    string       cur_name = "none";
    int          err_count = 0;
    int          test_errs = 0;
    int          test_in = 0;
    int          test_out = 0;
    int          tests_run = 0;

    // handshakes are sampled mid-cycle, where both sides are stable
    always @(negedge wclk) begin
        if (in_valid && in_ready) begin
            exp_q.push_back(in_entry);
            test_in++;
        end
    end

    always @(negedge rclk) begin
        fifo_entry_t exp;
        if (out_valid && out_ready) begin
            test_out++;
            if (exp_q.size() == 0) begin
                report_problem("an output entry arrived with nothing left to expect");
            end else begin
                exp = exp_q.pop_front();
                if (exp !== out_entry) begin
                    $display("Fail %s: expected %h actual %h", cur_name, exp, out_entry);
                    err_count++;
                    test_errs++;
                end
            end
        end
    end

    task automatic start_test(input string name);
        cur_name  = name;
        test_errs = 0;
        test_in   = 0;
        test_out  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s done: %0d in, %0d out, %0d errors",
                 cur_name, test_in, test_out, test_errs);
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s %s: expected %0d actual %0d", cur_name, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", cur_name, msg);
        err_count++;
        test_errs++;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic report_totals();
        $display("%0d tests run, %0d errors", tests_run, err_count);
    endtask

endmodule

/* verif/afifo_clk_gen.sv */
//----------------------------------------------------------------------
// clock and reset generator for one domain of the FIFO testbench
//----------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_clk_gen #(
    parameter int PERIOD     = 40,
    // used while alt_sel is high
    parameter int ALT_PERIOD = 40,
    parameter int RST_CYCLES = 10
) (
    input  logic alt_sel,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #((alt_sel ? ALT_PERIOD : PERIOD) / 2) clk = ~clk;
        end
    end

    // active low reset, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* rtl/afifo_top.sv */
//--------------------------------------------------------------------
// afifo top: dual-clock streaming FIFO with valid/ready on both sides
// and framed entries carried across the clock domains
//--------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_top
    import afifo_pkg::*;
#(
    // memory depth is 2**ADDR_W, total capacity one more
    parameter int ADDR_W = 4
) (
    // write side
    input  logic        wclk,
    input  logic        wrst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  fifo_entry_t in_entry,
    // read side
    input  logic        rclk,
    input  logic        rrst_n,
    output logic        out_valid,
    input  logic        out_ready,
    output fifo_entry_t out_entry
);

    // write controller to memory
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    fifo_entry_t       wr_entry;

    // read controller to and from memory
    logic [ADDR_W-1:0] rd_addr;
    fifo_entry_t       rd_entry;

    // Gray pointers crossing the domains
    logic [ADDR_W:0]   wr_gptr;
    logic [ADDR_W:0]   rd_gptr;

    afifo_wr_ctrl #(
        .ADDR_W (ADDR_W)
    ) i_wr_ctrl (
        .wclk     (wclk),
        .wrst_n   (wrst_n),
        .in_valid (in_valid),
        .in_entry (in_entry),
        .rd_gptr  (rd_gptr),
        .in_ready (in_ready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_entry (wr_entry),
        .wr_gptr  (wr_gptr)
    );

    afifo_mem #(
        .ADDR_W (ADDR_W)
    ) i_mem (
        .wclk     (wclk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_entry (wr_entry),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

    afifo_rd_ctrl #(
        .ADDR_W (ADDR_W)
    ) i_rd_ctrl (
        .rclk      (rclk),
        .rrst_n    (rrst_n),
        .wr_gptr   (wr_gptr),
        .rd_entry  (rd_entry),
        .out_ready (out_ready),
        .rd_addr   (rd_addr),
        .rd_gptr   (rd_gptr),
        .out_valid (out_valid),
        .out_entry (out_entry)
    );

endmodule

/* rtl/afifo_rd_ctrl.sv */
//--------------------------------------------------------------------
// afifo read controller: write pointer synchronizer, read pointers,
// empty flag and first-word fall-through output register
//--------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_rd_ctrl
    import afifo_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic              rclk,
    input  logic              rrst_n,
    input  logic [ADDR_W:0]   wr_gptr,
    input  fifo_entry_t       rd_entry,
    input  logic              out_ready,
    output logic [ADDR_W-1:0] rd_addr,
    output logic [ADDR_W:0]   rd_gptr,
    output logic              out_valid,
    output fifo_entry_t       out_entry
);

    typedef logic [ADDR_W:0] ptr_t;

    ptr_t       rbin;
    ptr_t       rbin_nxt;
    ptr_t       rgray_nxt;
    ptr_t       wq1_gptr;
    ptr_t       wq2_gptr;
    logic       empty;
    logic       empty_nxt;
    logic       load;
    out_state_t state;
    out_state_t state_nxt;

    // write pointer into rclk domain, two flops
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            wq1_gptr <= '0;
            wq2_gptr <= '0;
        end else begin
            wq1_gptr <= wr_gptr;
            wq2_gptr <= wq1_gptr;
        end
    end

    // fill the register when it is free or being consumed
    assign load = ~empty & (~out_valid | out_ready);

    assign rbin_nxt  = rbin + ptr_t'(load);
    assign rgray_nxt = (rbin_nxt >> 1) ^ rbin_nxt;
    assign rd_addr   = rbin[ADDR_W-1:0];

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rbin    <= '0;
            rd_gptr <= '0;
        end else begin
            rbin    <= rbin_nxt;
            rd_gptr <= rgray_nxt;
        end
    end

    // memory is empty once the read pointer catches the synced write pointer
    assign empty_nxt = (rgray_nxt == wq2_gptr);

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            empty <= 1'b1;
        end else begin
            empty <= empty_nxt;
        end
    end

    // output stage
    always_comb begin
        state_nxt = state;
        case (state)
            OUT_EMPTY: begin
                if (load) begin
                    state_nxt = OUT_HOLD;
                end
            end
            OUT_HOLD: begin
                // consumed with nothing to refill
                if (out_ready && !load) begin
                    state_nxt = OUT_EMPTY;
                end
            end
            default: begin
                state_nxt = OUT_EMPTY;
            end
        endcase
    end

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            state <= OUT_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    // entry is held while the reader stalls
    always_ff @(posedge rclk) begin
        if (load) begin
            out_entry <= rd_entry;
        end
    end

    assign out_valid = (state == OUT_HOLD);

endmodule

/* rtl/afifo_mem.sv */
//--------------------------------------------------------------------
// afifo storage: dual-port entry array, written on wclk and read
// asynchronously by address
//--------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_mem
    import afifo_pkg::*;
#(
    parameter int ADDR_W = 4
) (
    input  logic              wclk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  fifo_entry_t       wr_entry,
    input  logic [ADDR_W-1:0] rd_addr,
    output fifo_entry_t       rd_entry
);

    localparam int DEPTH = 1 << ADDR_W;

    fifo_entry_t mem [DEPTH];

    // write port in the wclk domain
    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // read port has no clock, the read controller registers the result
    assign rd_entry = mem[rd_addr];

endmodule

/* rtl/afifo_wr_ctrl.sv */
//--------------------------------------------------------------------
// afifo write controller: write handshake, binary and Gray pointers,
// read pointer synchronizer and registered full flag
//--------------------------------------------------------------------
`timescale 1ns/1ns

module afifo_wr_ctrl
    import afifo_pkg::*;
#(
    // depth is 2**ADDR_W, minimum 2 for the full compare
    parameter int ADDR_W = 4
) (
    input  logic              wclk,
    input  logic              wrst_n,
    input  logic              in_valid,
    input  fifo_entry_t       in_entry,
    input  logic [ADDR_W:0]   rd_gptr,
    output logic              in_ready,
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output fifo_entry_t       wr_entry,
    output logic [ADDR_W:0]   wr_gptr
);

    // pointers carry one wrap bit above the address
    typedef logic [ADDR_W:0] ptr_t;

    ptr_t wbin;
    ptr_t wbin_nxt;
    ptr_t wgray_nxt;
    ptr_t rq1_gptr;
    ptr_t rq2_gptr;
    ptr_t full_cmp;
    logic full;
    logic full_nxt;

    // accepted transfer writes memory at this same edge
    assign in_ready = ~full;
    assign wr_en    = in_valid & in_ready;
    assign wr_addr  = wbin[ADDR_W-1:0];
    assign wr_entry = in_entry;

    assign wbin_nxt  = wbin + ptr_t'(wr_en);
    assign wgray_nxt = (wbin_nxt >> 1) ^ wbin_nxt;

    // read pointer into wclk domain, two flops
    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            rq1_gptr <= '0;
            rq2_gptr <= '0;
        end else begin
            rq1_gptr <= rd_gptr;
            rq2_gptr <= rq1_gptr;
        end
    end

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            wbin    <= '0;
            wr_gptr <= '0;
        end else begin
            wbin    <= wbin_nxt;
            wr_gptr <= wgray_nxt;
        end
    end

    // full when the next write pointer is one lap ahead of the read pointer
    // in Gray code that means the top two bits differ and the rest match
    assign full_cmp = {~rq2_gptr[ADDR_W -: 2], rq2_gptr[ADDR_W-2:0]};
    assign full_nxt = (wgray_nxt == full_cmp);

    // registered from the next pointer, so in_ready drops the cycle after
    // the filling write
    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            full <= 1'b0;
        end else begin
            full <= full_nxt;
        end
    end

endmodule

/* rtl/afifo_pkg.sv */
//--------------------------------------------------------------------
// afifo package: shared word, entry and output-stage types for the
// dual-clock streaming FIFO
//--------------------------------------------------------------------

package afifo_pkg;

    // payload width of one data word
    localparam int DATA_W = 8;

    // one payload word
    typedef logic [DATA_W-1:0] fifo_word_t;

    // unit stored in memory and passed on both ports
    // last marks the final word of a frame
    typedef struct packed {
        fifo_word_t data;
        logic       last;
    } fifo_entry_t;

    // output register state in the read controller
    // OUT_EMPTY: register holds nothing valid
    // OUT_HOLD: register holds an entry offered on the read port
    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_HOLD  = 1'b1
    } out_state_t;

endpackage
